// ==== isa_pkg.sv ====
/*
 * Instruction word layout of the 16-bit accumulator CPU.
 * Opcode sits in bits 15:12 in both formats.
 * Opcodes 8 to 15 are unassigned and run as a fetch plus a no-op step.
 */
package isa_pkg;

   ////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////
   typedef enum logic [3:0] {
      op_and   = 4'h0,  // AC and operand
      op_add   = 4'h1,  // AC plus operand
      op_load  = 4'h2,  // Operand to AC
      op_store = 4'h3,  // AC to memory
      op_jmp   = 4'h4,  // Address to PC
      op_iot   = 4'h5,  // I/O read into AC
      op_opr   = 4'h6,  // Flag and AC micro-ops from the word itself
      op_skl   = 4'h7   // Skip if link set
   } opcode_t;

   // Memory reference view
   typedef struct packed {
      opcode_t     opcode;
      logic        indirect;  // Indirect bit, not decoded by the sequencer
      logic [10:0] addr;      // Operand address
   } mem_fmt_t;

   // Operate view, bits 11 down to 7
   typedef struct packed {
      opcode_t    opcode;
      logic       cpl;     // Complement link
      logic       cll;     // Clear link
      logic       sti;     // Set interrupt enable
      logic       cli;     // Clear interrupt enable
      logic       inc_ac;  // Increment AC
      logic [6:0] spare;
   } opr_fmt_t;

   // One word, two decodes
   typedef union packed {
      mem_fmt_t mem_fmt;
      opr_fmt_t opr_fmt;
   } instr_u;

endpackage

// ==== ucode_pkg.sv ====
/*
 * Microcode control word and address layout.
 * Bit positions of the control word match the 24-bit ROM image,
 * bit 18 is reserved and always zero.
 */
package ucode_pkg;

   ////////////////////////////////////////
   // Unit selects and ALU operations
   ////////////////////////////////////////
   typedef enum logic [3:0] {
      ru_none    = 4'h0,  // Bus reads as zero
      ru_ac      = 4'h1,
      ru_pc      = 4'h2,
      ru_dr      = 4'h3,
      ru_mem     = 4'h4,  // Memory data
      ru_io      = 4'h5,  // I/O data
      ru_ir_addr = 4'h6   // Address field of IR
   } unit_sel_t;

   typedef enum logic [2:0] {
      wu_none = 3'h0,
      wu_ac   = 3'h1,
      wu_pc   = 3'h2,
      wu_dr   = 3'h3,
      wu_ir   = 3'h4,
      wu_mem  = 3'h5,  // Memory write data
      wu_io   = 3'h6
   } wunit_sel_t;

   typedef enum logic [3:0] {
      alu_pass = 4'h0,
      alu_and  = 4'h1,
      alu_add  = 4'h2,
      alu_not  = 4'h3
   } alu_op_t;

   ////////////////////////////////////////
   // Control word, bit 23 down to bit 0
   ////////////////////////////////////////
   typedef struct packed {
      logic       uend;      // End of instruction
      logic       wen;       // Write cycle
      logic       r;         // Read cycle
      logic       io;        // I/O cycle
      logic       mem;       // Memory cycle
      logic       reserved;
      logic       inc_dr;
      logic       inc_pc;
      logic       cli;
      logic       sti;
      logic       cll;
      logic       cpl;
      logic       inc_ac;
      alu_op_t    opif;
      wunit_sel_t wunit;
      unit_sel_t  runit;
   } ctrl_word_t;

   typedef logic [3:0] upc_t;  // Microstep

   // ROM address
   typedef struct packed {
      logic             irq_taken;
      logic             link;
      isa_pkg::opcode_t opcode;
      logic             skip;
      logic             aindex;
      upc_t             upc;
   } uaddr_t;

endpackage

// ==== ucode_bus_if.sv ====
/*
 * Handshake between the sequencer and the bus engine.
 * start is a single-cycle pulse; is_io and is_write are sampled with it.
 */
interface ucode_bus_if;

   logic start;     // Begin a bus cycle
   logic is_io;     // I/O space, else memory
   logic is_write;  // Write, else read
   logic busy;      // Cycle in flight
   logic timeout;   // Ack never came, one-cycle pulse

   // Sequencer side
   modport seq (
      output start,
      output is_io,
      output is_write,
      input  busy,
      input  timeout
   );

   // Bus engine side
   modport engine (
      input  start,
      input  is_io,
      input  is_write,
      output busy,
      output timeout
   );

endinterface

// ==== upc_counter.sv ====
/*
 * Microcode step counter.
 * Priority is reset, hold, clear on end, increment.
 * Wraps after step 15 if the table has no end bit there.
 */
module upc_counter (
   input  logic            clk1,
   input  logic            rst,
   input  logic            hold,  // Step not finished
   input  logic            uend,  // Last step of the instruction
   output ucode_pkg::upc_t upc
);

   always_ff @(posedge clk1) begin
      if (rst) begin
         upc <= '0;
      end else if (!hold) begin
         if (uend) begin
            upc <= '0;  // Back to fetch
         end else begin
            upc <= upc + 4'd1;
         end
      end
   end

endmodule

// ==== ucode_rom.sv ====
/*
 * Microcode table, purely combinational.
 * Step 0 fetches for every opcode. An interrupt replaces the opcode from step 1.
 * Unused steps only raise end, so the counter always returns to fetch.
 */
module ucode_rom (
   input  ucode_pkg::uaddr_t     uaddr,
   output ucode_pkg::ctrl_word_t ctrl
);
   import isa_pkg::*;
   import ucode_pkg::*;

   upc_t oper_step;  // Step of the operand cycle

   // Auto-index inserts two steps ahead of the operand
   assign oper_step = uaddr.aindex ? 4'd4 : 4'd2;

   always_comb begin
      ctrl = '0;
      if (uaddr.upc == 4'd0) begin
         ////////////////////////////////////////
         // Fetch
         ////////////////////////////////////////
         ctrl.runit  = ru_mem;
         ctrl.wunit  = wu_ir;
         ctrl.mem    = 1'b1;
         ctrl.r      = 1'b1;
         ctrl.inc_pc = 1'b1;  // PC now points past the instruction
      end else if (uaddr.irq_taken) begin
         ////////////////////////////////////////
         // Interrupt entry
         ////////////////////////////////////////
         case (uaddr.upc)
            4'd1: begin  // Save return PC
               ctrl.runit = ru_pc;
               ctrl.wunit = wu_mem;
               ctrl.mem   = 1'b1;
               ctrl.wen   = 1'b1;
            end
            4'd2: begin  // PC to vector 0, mask further interrupts
               ctrl.runit = ru_none;
               ctrl.wunit = wu_pc;
               ctrl.opif  = alu_pass;
               ctrl.cli   = 1'b1;
               ctrl.uend  = 1'b1;
            end
            default: ctrl.uend = 1'b1;
         endcase
      end else begin
         case (uaddr.opcode)
            op_and, op_add, op_load, op_store: begin
               if (uaddr.upc == 4'd1) begin
                  ctrl.runit = ru_ir_addr;  // Operand address to DR
                  ctrl.wunit = wu_dr;
               end else if (uaddr.aindex && uaddr.upc == 4'd2) begin
                  ctrl.inc_dr = 1'b1;       // Bump pointer
               end else if (uaddr.aindex && uaddr.upc == 4'd3) begin
                  ctrl.runit = ru_dr;       // Write pointer back
                  ctrl.wunit = wu_mem;
                  ctrl.mem   = 1'b1;
                  ctrl.wen   = 1'b1;
               end else if (uaddr.upc == oper_step) begin
                  ctrl.mem  = 1'b1;
                  ctrl.uend = 1'b1;
                  if (uaddr.opcode == op_store) begin
                     ctrl.runit = ru_ac;
                     ctrl.wunit = wu_mem;
                     ctrl.wen   = 1'b1;
                  end else begin
                     ctrl.runit = ru_mem;
                     ctrl.wunit = wu_ac;
                     ctrl.r     = 1'b1;
                     ctrl.opif  = (uaddr.opcode == op_and) ? alu_and :
                                  (uaddr.opcode == op_add) ? alu_add : alu_pass;
                  end
               end else begin
                  ctrl.uend = 1'b1;
               end
            end
            op_jmp: begin
               ctrl.runit = ru_ir_addr;
               ctrl.wunit = wu_pc;
               ctrl.uend  = 1'b1;
            end
            op_iot: begin
               if (uaddr.upc == 4'd1) begin  // I/O read into AC
                  ctrl.runit = ru_io;
                  ctrl.wunit = wu_ac;
                  ctrl.io    = 1'b1;
                  ctrl.r     = 1'b1;
               end else begin
                  ctrl.inc_pc = uaddr.skip;  // Device skip
                  ctrl.uend   = 1'b1;
               end
            end
            op_skl: begin
               ctrl.inc_pc = uaddr.link;
               ctrl.uend   = 1'b1;
            end
            default: ctrl.uend = 1'b1;  // op_opr strobes come from IR
         endcase
      end
   end

endmodule

// ==== flag_unit.sv ====
/*
 * Link and interrupt-enable flags.
 * Updated once per completed microstep. Clear link acts before complement,
 * clear interrupt enable wins over set.
 */
module flag_unit (
   input  logic clk1,
   input  logic rst,
   input  logic step_done,  // Counter advances this edge
   input  logic cpl,
   input  logic cll,
   input  logic sti,
   input  logic cli,
   output logic link,
   output logic intr_en
);

   logic link_cleared;  // Link after clear, before complement

   assign link_cleared = cll ? 1'b0 : link;

   always_ff @(posedge clk1) begin
      if (rst) begin
         link    <= 1'b0;
         intr_en <= 1'b0;
      end else if (step_done) begin
         link <= link_cleared ^ cpl;  // cll then cpl gives set
         if (cli) begin
            intr_en <= 1'b0;
         end else if (sti) begin
            intr_en <= 1'b1;
         end
      end
   end

endmodule

// ==== bus_cycle_fsm.sv ====
/*
 * Four-phase req/ack engine for memory and I/O cycles.
 * Cycle kind is latched at start and held while req is high.
 * Expects ack_timeout of 2 or more. A timed-out cycle drops req without ack.
 */
module bus_cycle_fsm #(
   parameter int ack_timeout = 64  // Cycles to wait for ack
) (
   input  logic        clk1,
   input  logic        rst,
   ucode_bus_if.engine ctl,
   output logic        bus_req,
   output logic        bus_io,
   output logic        bus_write,
   input  logic        bus_ack
);

   localparam int cnt_w = $clog2(ack_timeout + 1);

   typedef enum logic [1:0] {
      idle,      // Waiting for start
      req_high,  // Req up, waiting for ack
      req_low,   // Req down, waiting for ack to drop
      finish     // Settle cycle, busy still high
   } state_t;

   state_t           state;
   logic [cnt_w-1:0] wait_cnt;   // Cycles spent in req_high
   logic             timed_out;

   always_ff @(posedge clk1) begin
      if (rst) begin
         state     <= idle;
         wait_cnt  <= '0;
         timed_out <= 1'b0;
         bus_io    <= 1'b0;
         bus_write <= 1'b0;
      end else begin
         timed_out <= 1'b0;  // Pulse only
         case (state)
            idle: begin
               wait_cnt <= '0;
               if (ctl.start) begin
                  state     <= req_high;
                  bus_io    <= ctl.is_io;  // Stable for the whole cycle
                  bus_write <= ctl.is_write;
               end
            end
            req_high: begin
               wait_cnt <= wait_cnt + 1'b1;
               if (bus_ack) begin
                  state <= req_low;
               end else if (wait_cnt == cnt_w'(ack_timeout - 1)) begin
                  state     <= finish;  // Give up, release sequencer
                  timed_out <= 1'b1;
               end
            end
            req_low: begin
               if (!bus_ack) begin
                  state <= finish;
               end
            end
            default: state <= idle;  // finish
         endcase
      end
   end

   assign bus_req     = (state == req_high);
   assign ctl.busy    = (state != idle);  // High from the cycle after start
   assign ctl.timeout = timed_out;

endmodule

// ==== useq_top.sv ====
/*
 * Microcode sequencer top. ir, irq, skip and aindex must be stable for the
 * whole instruction, as the table is read combinationally every cycle.
 * A bus cycle starts on the first cycle of a step with mem or io set.
 */
module useq_top #(
   parameter int ack_timeout = 64
) (
   input  logic                  clk1,
   input  logic                  rst,
   input  logic [15:0]           ir,
   input  logic                  irq,
   input  logic                  halt,
   input  logic                  skip,
   input  logic                  aindex,
   input  logic                  bus_ack,
   output ucode_pkg::upc_t       upc,
   output ucode_pkg::unit_sel_t  runit,
   output ucode_pkg::wunit_sel_t wunit,
   output ucode_pkg::alu_op_t    opif,
   output logic                  inc_ac,
   output logic                  inc_pc,
   output logic                  inc_dr,
   output logic                  link,
   output logic                  intr_en,
   output logic                  bus_req,
   output logic                  bus_io,
   output logic                  bus_write,
   output logic                  bus_timeout
);
   import isa_pkg::*;
   import ucode_pkg::*;

   instr_u     instr;
   uaddr_t     uaddr;
   ctrl_word_t ctrl;
   logic       irq_taken;
   logic       opr_step;    // Execute step of op_opr
   logic       step_first;  // First cycle of the current step
   logic       hold;
   logic       step_done;
   logic       cpl, cll, sti, cli;

   ucode_bus_if ctl_if ();

   ////////////////////////////////////////
   // Microcode address
   ////////////////////////////////////////
   assign instr     = ir;
   assign irq_taken = irq & intr_en;

   always_comb begin
      uaddr.irq_taken = irq_taken;
      uaddr.link      = link;
      uaddr.opcode    = instr.mem_fmt.opcode;
      uaddr.skip      = skip;
      uaddr.aindex    = aindex;
      uaddr.upc       = upc;
   end

   ucode_rom rom_i (.uaddr(uaddr), .ctrl(ctrl));

   ////////////////////////////////////////
   // Step timing
   ////////////////////////////////////////
   always_ff @(posedge clk1) begin
      if (rst) begin
         step_first <= 1'b1;
      end else if (step_done) begin
         step_first <= 1'b1;  // Next step begins
      end else if (ctl_if.start) begin
         step_first <= 1'b0;  // One start per step
      end
   end

   assign ctl_if.start    = step_first & (ctrl.mem | ctrl.io) & ~halt;
   assign ctl_if.is_io    = ctrl.io;
   assign ctl_if.is_write = ctrl.wen;
   assign hold            = halt | ctl_if.busy | ctl_if.start;
   assign step_done       = ~hold;

   upc_counter upc_i (
      .clk1(clk1), .rst(rst), .hold(hold), .uend(ctrl.uend), .upc(upc)
   );

   // Operate bits act on the single step after fetch
   assign opr_step = (instr.opr_fmt.opcode == op_opr) && !irq_taken && (upc == 4'd1);
   assign cpl      = ctrl.cpl | (opr_step & instr.opr_fmt.cpl);
   assign cll      = ctrl.cll | (opr_step & instr.opr_fmt.cll);
   assign sti      = ctrl.sti | (opr_step & instr.opr_fmt.sti);
   assign cli      = ctrl.cli | (opr_step & instr.opr_fmt.cli);

   flag_unit flag_i (
      .clk1(clk1), .rst(rst), .step_done(step_done),
      .cpl(cpl), .cll(cll), .sti(sti), .cli(cli),
      .link(link), .intr_en(intr_en)
   );

   bus_cycle_fsm #(.ack_timeout(ack_timeout)) bus_i (
      .clk1(clk1), .rst(rst), .ctl(ctl_if),
      .bus_req(bus_req), .bus_io(bus_io), .bus_write(bus_write), .bus_ack(bus_ack)
   );

   // Datapath steering
   assign runit       = ctrl.runit;
   assign wunit       = ctrl.wunit;
   assign opif        = ctrl.opif;
   assign inc_ac      = ctrl.inc_ac | (opr_step & instr.opr_fmt.inc_ac);
   assign inc_pc      = ctrl.inc_pc;
   assign inc_dr      = ctrl.inc_dr;
   assign bus_timeout = ctl_if.timeout;

endmodule

// ==== useq_assert.sv ====
/*
 * Bus handshake and counter checks, bound into useq_top.
 * A timed-out cycle may drop req without ack.
 */
module useq_bus_assert (
   input logic       clk1,
   input logic       rst,
   input logic       bus_req,
   input logic       bus_ack,
   input logic       bus_io,
   input logic       bus_write,
   input logic       bus_timeout,
   input logic [3:0] upc
);

   // Req only falls after ack, or on a timeout
   req_holds_for_ack: assert property (@(posedge clk1) disable iff (rst)
      $fell(bus_req) |-> ($past(bus_ack) || bus_timeout))
      else $error("bus_req dropped before bus_ack");

   // Cycle kind fixed while req is up
   kind_stable: assert property (@(posedge clk1) disable iff (rst)
      (bus_req && $past(bus_req)) |-> ($stable(bus_io) && $stable(bus_write)))
      else $error("bus_io or bus_write changed during a bus cycle");

   upc_frozen: assert property (@(posedge clk1) disable iff (rst)
      bus_req |=> $stable(upc))  // Step cannot end with req up
      else $error("upc moved during a bus cycle");

   req_low_in_reset: assert property (@(posedge clk1) rst |=> !bus_req)
      else $error("bus_req high in reset");

endmodule

bind useq_top useq_bus_assert assert_i (
   .clk1(clk1), .rst(rst), .bus_req(bus_req), .bus_ack(bus_ack),
   .bus_io(bus_io), .bus_write(bus_write), .bus_timeout(bus_timeout), .upc(upc)
);

// ==== tb_useq.sv ====
/*
 * Testbench for useq_top. Vectors come from useq_testdata.txt, one
 * instruction per line. Inputs stay stable for a whole instruction.
 * The bus target answers after the record's delay, 255 means never.
 */
module tb_useq;

   logic        clk1, rst, irq, halt, skip, aindex, bus_ack;
   logic [15:0] ir;
   logic [3:0]  upc, runit, opif;
   logic [2:0]  wunit;
   logic        inc_ac, inc_pc, inc_dr, link, intr_en;
   logic        bus_req, bus_io, bus_write, bus_timeout;

   // Records
   logic [15:0] rec_ir [0:31];
   logic        rec_irq [0:31], rec_skip [0:31], rec_aindex [0:31];
   logic        rec_link [0:31], rec_ie [0:31], rec_to [0:31];
   int          rec_delay [0:31], rec_n [0:31];
   logic [19:0] rec_step [0:31][0:4];
   int          nrec;

   int          errors, checks, cycles, limit;
   int          cur, k, ack_cnt, delay;
   logic [3:0]  prev_upc;
   logic        first, done, saw_timeout;
   logic [19:0] cur_w;    // Tabled word of the step under way
   logic        saw_req;  // bus_req seen in this step

   useq_top #(.ack_timeout(64)) dut_i (
      .clk1(clk1), .rst(rst), .ir(ir), .irq(irq), .halt(halt), .skip(skip),
      .aindex(aindex), .bus_ack(bus_ack), .upc(upc), .runit(runit),
      .wunit(wunit), .opif(opif), .inc_ac(inc_ac), .inc_pc(inc_pc),
      .inc_dr(inc_dr), .link(link), .intr_en(intr_en), .bus_req(bus_req),
      .bus_io(bus_io), .bus_write(bus_write), .bus_timeout(bus_timeout)
   );

   initial begin
      clk1 = 1'b0;
      forever #5 clk1 = ~clk1;
   end

   // One compare, one Mismatch line on failure
   task automatic check_field(input string name, input logic [15:0] exp,
                              input logic [15:0] got);
      checks++;
      if (got !== exp) begin
         $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   ////////////////////////////////////////
   // Vector file
   ////////////////////////////////////////
   task automatic read_vectors();
      int    fd, cnt;
      string line;
      logic [15:0] f_ir;
      logic [3:0]  f_irq, f_skip, f_ai, f_link, f_ie, f_to;
      int          f_delay, f_n;
      logic [19:0] s0, s1, s2, s3, s4;
      nrec = 0;
      fd = $fopen("useq_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open the test vector file");
         errors++;
         return;
      end
      while (!$feof(fd) && nrec < 32) begin
         line = "";
         cnt = $fgets(line, fd);
         if (line.len() < 2 || line.getc(0) == 8'h23) continue;  // Blank or comment
         cnt = $sscanf(line, "%h %h %h %h %d %h %h %h %d %h %h %h %h %h",
                       f_ir, f_irq, f_skip, f_ai, f_delay, f_link, f_ie, f_to,
                       f_n, s0, s1, s2, s3, s4);
         if (cnt != 14) begin
            $display("Malformed vector line: %s", line);
            errors++;
            continue;
         end
         rec_ir[nrec]     = f_ir;
         rec_irq[nrec]    = f_irq[0];
         rec_skip[nrec]   = f_skip[0];
         rec_aindex[nrec] = f_ai[0];
         rec_delay[nrec]  = f_delay;
         rec_link[nrec]   = f_link[0];
         rec_ie[nrec]     = f_ie[0];
         rec_to[nrec]     = f_to[0];
         rec_n[nrec]      = f_n;
         rec_step[nrec][0] = s0;
         rec_step[nrec][1] = s1;
         rec_step[nrec][2] = s2;
         rec_step[nrec][3] = s3;
         rec_step[nrec][4] = s4;
         nrec++;
      end
      $fclose(fd);
   endtask

   // Outputs of the current step against the tabled word
   task automatic check_step(input logic [19:0] w);
      check_field("upc", 16'(w[19:16]), 16'(upc));
      check_field("runit", 16'(w[15:12]), 16'(runit));
      check_field("wunit", 16'(w[11:8]), 16'(wunit));
      check_field("opif", 16'(w[7:4]), 16'(opif));
      check_field("strobes", 16'(w[3:0]), 16'({inc_ac, inc_pc, inc_dr}));
   endtask

   // Read unit codes mem 4 and io 5
   // Write unit codes mem 5 and io 6
   function automatic logic needs_bus(input logic [19:0] w);
      return (w[15:12] inside {4'h4, 4'h5}) || (w[11:8] inside {4'h5, 4'h6});
   endfunction

   function automatic logic io_cycle(input logic [19:0] w);
      return (w[15:12] == 4'h5) || (w[11:8] == 4'h6);
   endfunction

   function automatic logic write_cycle(input logic [19:0] w);
      return w[11:8] inside {4'h5, 4'h6};  // Data goes out to memory or I/O
   endfunction

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////
   initial begin
      rst = 1'b1;
      ir = '0;
      irq = 1'b0;
      halt = 1'b0;
      skip = 1'b0;
      aindex = 1'b0;
      bus_ack = 1'b0;
      errors = 0;
      checks = 0;
      cycles = 0;
      cur = -1;
      k = 0;
      ack_cnt = 0;
      delay = 0;
      first = 1'b1;
      done = 1'b0;
      saw_timeout = 1'b0;
      saw_req = 1'b0;
      cur_w = '0;
      prev_upc = '0;
      read_vectors();
      limit = 200;
      for (int i = 0; i < nrec; i++) begin
         limit += rec_n[i] * (rec_delay[i] + 4);
      end
      if (nrec == 0) done = 1'b1;  // Nothing to run

      repeat (5) @(posedge clk1);
      #1 rst = 1'b0;

      while (!done && cycles < limit) begin
         @(negedge clk1);
         cycles++;
         if (bus_timeout) saw_timeout = 1'b1;
         if (first || upc != prev_upc) begin  // First cycle of a new step
            if (!first) begin  // Bus use of the step just ended
               check_field("bus_req seen", 16'(needs_bus(cur_w)), 16'(saw_req));
            end
            first = 1'b0;
            saw_req = 1'b0;
            if (cur < 0 || k == rec_n[cur]) begin
               check_field("upc after end", 16'h0, 16'(upc));
               if (cur >= 0) begin  // Flags after the last step
                  check_field("link", 16'(rec_link[cur]), 16'(link));
                  check_field("intr_en", 16'(rec_ie[cur]), 16'(intr_en));
                  check_field("bus_timeout seen", 16'(rec_to[cur]), 16'(saw_timeout));
               end
               cur++;
               k = 0;
               saw_timeout = 1'b0;
               if (cur == nrec) begin
                  done = 1'b1;
               end else begin
                  delay = rec_delay[cur];
               end
            end
            if (!done) begin
               cur_w = rec_step[cur][k];
               check_step(cur_w);
               k++;
            end
         end
         if (bus_req && !done) begin  // Cycle kind follows the tabled units
            saw_req = 1'b1;
            check_field("bus_io", 16'(io_cycle(cur_w)), 16'(bus_io));
            check_field("bus_write", 16'(write_cycle(cur_w)), 16'(bus_write));
         end
         prev_upc = upc;

         @(posedge clk1);
         #1;
         if (cur >= 0 && cur < nrec) begin
            ir     = rec_ir[cur];
            irq    = rec_irq[cur];
            skip   = rec_skip[cur];
            aindex = rec_aindex[cur];
         end
         // Bus target, four-phase
         if (bus_req && !bus_ack) begin
            if (delay != 255 && ack_cnt >= delay) bus_ack = 1'b1;
            else ack_cnt++;
         end else if (!bus_req) begin
            bus_ack = 1'b0;
            ack_cnt = 0;
         end
      end

      if (!done) begin
         $display("Run stopped at the cycle limit of %0d with record %0d unfinished",
                  limit, cur);
         errors++;
      end
      $display("Summary: %0d records, %0d checks, %0d errors", nrec, checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== build.f ====
isa_pkg.sv
ucode_pkg.sv
ucode_bus_if.sv
upc_counter.sv
ucode_rom.sv
flag_unit.sv
bus_cycle_fsm.sv
useq_top.sv
useq_assert.sv
tb_useq.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the microcode sequencer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_useq \
   -Mdir obj_dir -o tb_useq_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_useq_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
   exit 0
fi
exit 1

// ==== useq_testdata.txt ====
# ir irq skip aindex delay(dec) link ie timeout nsteps(dec) then 5 step words
# step word hex digits: upc runit wunit opif strobes{inc_ac,inc_pc,inc_dr}
2005 0 0 0 0   0 0 0 3 04402 16300 24100 00000 00000
1010 0 0 0 3   0 0 0 3 04402 16300 24120 00000 00000
0040 0 0 1 9   0 0 0 5 04402 16300 20001 33500 44110
3020 0 0 0 1   0 0 0 3 04402 16300 21500 00000 00000
4100 0 0 0 2   0 0 0 2 04402 16200 00000 00000 00000
5003 0 1 0 5   0 0 0 3 04402 15100 20002 00000 00000
7000 0 0 0 0   0 0 0 2 04402 10000 00000 00000 00000
6A00 0 0 0 4   1 1 0 2 04402 10000 00000 00000 00000
7000 0 0 0 1   1 1 0 2 04402 10002 00000 00000 00000
6480 0 0 0 0   0 1 0 2 04402 10004 00000 00000 00000
2005 1 0 0 2   0 0 0 3 04402 12500 20200 00000 00000
4100 1 0 0 0   0 0 0 2 04402 16200 00000 00000 00000
6C00 0 0 0 6   1 0 0 2 04402 10000 00000 00000 00000
4100 0 0 0 255 1 0 1 2 04402 16200 00000 00000 00000
2030 0 0 1 7   1 0 0 5 04402 16300 20001 33500 44100
